// ==== verilog/muldiv_pkg.sv ====
package muldiv_pkg;

    // ########################################################
    // field widths
    // ########################################################

    localparam int UUID_BITS = 44;
    localparam int NW_BITS   = 2;   // warp id
    localparam int NR_BITS   = 5;   // register index

    // multiplies first, then the divide group
    typedef enum logic [2:0] {
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } mul_op_e;

    typedef struct packed {
        logic [UUID_BITS-1:0] uuid;
        logic [NW_BITS-1:0]   wid;
        logic [31:0]          pc;
        logic [NR_BITS-1:0]   rd;
        logic                 wb;
    } muldiv_tag_t;

    // lane independent part of a request
    typedef struct packed {
        mul_op_e     op;
        muldiv_tag_t tag;
    } muldiv_req_t;

    // ########################################################
    // op decode
    // ########################################################

    function automatic logic is_div_op(mul_op_e op);
        return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

    function automatic logic is_mulh(mul_op_e op);
        return op inside {OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    function automatic logic mul_signed_a(mul_op_e op);
        return op != OP_MULHU;
    endfunction

    // low word of MUL does not care about sign
    function automatic logic mul_signed_b(mul_op_e op);
        return op inside {OP_MUL, OP_MULH};
    endfunction

    function automatic logic is_rem(mul_op_e op);
        return op inside {OP_REM, OP_REMU};
    endfunction

    function automatic logic div_signed(mul_op_e op);
        return op inside {OP_DIV, OP_REM};
    endfunction

endpackage

// ==== verilog/muldiv_skid_buf.sv ====
`timescale 1ns/1ps

module muldiv_skid_buf #(
    parameter int NUM_THREADS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  muldiv_pkg::muldiv_req_t      in_req,
    input  logic [NUM_THREADS-1:0]       in_tmask,
    input  logic [NUM_THREADS-1:0][31:0] in_a,
    input  logic [NUM_THREADS-1:0][31:0] in_b,
    input  logic                         in_valid,
    output logic                         in_ready,
    output muldiv_pkg::muldiv_req_t      out_req,
    output logic [NUM_THREADS-1:0]       out_tmask,
    output logic [NUM_THREADS-1:0][31:0] out_a,
    output logic [NUM_THREADS-1:0][31:0] out_b,
    output logic                         out_valid,
    input  logic                         out_ready
);
    import muldiv_pkg::*;

    typedef struct packed {
        muldiv_req_t                  req;
        logic [NUM_THREADS-1:0]       tmask;
        logic [NUM_THREADS-1:0][31:0] a;
        logic [NUM_THREADS-1:0][31:0] b;
    } entry_t;

    entry_t in_ent, main_q, spare_q;
    logic   main_vld, spare_vld;
    logic   main_vld_d, spare_vld_d;
    logic   in_fire, main_free;

    assign in_ent.req   = in_req;
    assign in_ent.tmask = in_tmask;
    assign in_ent.a     = in_a;
    assign in_ent.b     = in_b;

    assign in_fire   = in_valid && in_ready;
    assign main_free = !main_vld || out_ready;  // main drains this cycle

    always_comb begin
        main_vld_d  = main_vld;
        spare_vld_d = spare_vld;
        if (main_free) begin
            main_vld_d  = spare_vld || in_fire;
            spare_vld_d = 1'b0;
        end else if (in_fire) begin
            spare_vld_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_vld  <= 1'b0;
            spare_vld <= 1'b0;
            in_ready  <= 1'b0;
        end else begin
            main_vld  <= main_vld_d;
            spare_vld <= spare_vld_d;
            in_ready  <= !spare_vld_d;   // registered, never from out_ready
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_q <= spare_vld ? spare_q : in_ent;
        end else if (in_fire) begin
            spare_q <= in_ent;
        end
    end

    assign out_valid = main_vld;
    assign out_req   = main_q.req;
    assign out_tmask = main_q.tmask;
    assign out_a     = main_q.a;
    assign out_b     = main_q.b;

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_fire |-> !(main_vld && spare_vld))
        else $error("skid buffer written while both entries full");

endmodule

// ==== verilog/mul_pipeline.sv ====
`timescale 1ns/1ps

module mul_pipeline #(
    parameter int NUM_THREADS  = 4,
    parameter int LATENCY_IMUL = 3
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  logic                         in_valid,
    input  muldiv_pkg::muldiv_req_t      in_req,
    input  logic [NUM_THREADS-1:0]       in_tmask,
    input  logic [NUM_THREADS-1:0][31:0] a,
    input  logic [NUM_THREADS-1:0][31:0] b,
    output logic                         out_valid,
    output muldiv_pkg::muldiv_tag_t      out_tag,
    output logic [NUM_THREADS-1:0]       out_tmask,
    output logic [NUM_THREADS-1:0][31:0] result
);
    import muldiv_pkg::*;

    typedef struct packed {
        muldiv_tag_t            tag;
        logic [NUM_THREADS-1:0] tmask;
        logic                   mulh;
    } meta_t;

    logic                         sgn_a, sgn_b;
    logic [NUM_THREADS-1:0][63:0] prod_d;
    logic [NUM_THREADS-1:0][63:0] prod_q [LATENCY_IMUL];
    meta_t                        meta_d;
    meta_t                        meta_q [LATENCY_IMUL];
    logic [LATENCY_IMUL-1:0]      vld_q;

    assign sgn_a = mul_signed_a(in_req.op);
    assign sgn_b = mul_signed_b(in_req.op);

    assign meta_d.tag   = in_req.tag;
    assign meta_d.tmask = in_tmask;
    assign meta_d.mulh  = is_mulh(in_req.op);

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        logic signed [32:0] op_a, op_b;
        logic signed [65:0] full;

        assign op_a      = {sgn_a & a[i][31], a[i]};
        assign op_b      = {sgn_b & b[i][31], b[i]};
        assign full      = op_a * op_b;
        assign prod_d[i] = full[63:0];   // 64 bits cover both words

        assign result[i] = meta_q[LATENCY_IMUL-1].mulh ? prod_q[LATENCY_IMUL-1][i][63:32]
                                                       : prod_q[LATENCY_IMUL-1][i][31:0];
    end

    // ########################################################
    // stage registers, all advance together
    // ########################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (enable) begin
            vld_q[0] <= in_valid;
            for (int s = 1; s < LATENCY_IMUL; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            prod_q[0] <= prod_d;
            meta_q[0] <= meta_d;
            for (int s = 1; s < LATENCY_IMUL; s++) begin
                prod_q[s] <= prod_q[s-1];
                meta_q[s] <= meta_q[s-1];
            end
        end
    end

    assign out_valid = vld_q[LATENCY_IMUL-1];
    assign out_tag   = meta_q[LATENCY_IMUL-1].tag;
    assign out_tmask = meta_q[LATENCY_IMUL-1].tmask;

endmodule

// ==== verilog/serial_divider.sv ====
`timescale 1ns/1ps

module serial_divider #(
    parameter int NUM_THREADS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic                         signed_mode,
    input  muldiv_pkg::muldiv_tag_t      in_tag,
    input  logic [NUM_THREADS-1:0]       in_tmask,
    input  logic                         rem_sel,
    input  logic [NUM_THREADS-1:0][31:0] numer,
    input  logic [NUM_THREADS-1:0][31:0] denom,
    output logic                         out_valid,
    input  logic                         out_ready,
    output muldiv_pkg::muldiv_tag_t      out_tag,
    output logic [NUM_THREADS-1:0]       out_tmask,
    output logic [NUM_THREADS-1:0][31:0] out_data
);
    import muldiv_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ITER,
        FIX,
        DONE
    } div_state_e;

    // request context held for the whole operation
    typedef struct packed {
        muldiv_tag_t            tag;
        logic [NUM_THREADS-1:0] tmask;
        logic                   sgn;
        logic                   rem;
    } ctx_t;

    div_state_e state;
    logic [4:0] cnt;
    ctx_t       ctx_q;

    logic [NUM_THREADS-1:0][31:0] numer_q, denom_q;
    logic [NUM_THREADS-1:0][31:0] dmag_q, quo_q, rem_q, res_q;
    logic [NUM_THREADS-1:0][31:0] n_abs, d_abs, q_fix, r_fix;
    logic [NUM_THREADS-1:0][32:0] r_shift, diff;

    // ########################################################
    // per lane datapath
    // ########################################################

    always_comb begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            n_abs[i] = (ctx_q.sgn && numer_q[i][31]) ? -numer_q[i] : numer_q[i];
            d_abs[i] = (ctx_q.sgn && denom_q[i][31]) ? -denom_q[i] : denom_q[i];

            // one restoring step
            r_shift[i] = {rem_q[i], quo_q[i][31]};
            diff[i]    = r_shift[i] - {1'b0, dmag_q[i]};

            // quotient sign from both operands, remainder follows dividend
            q_fix[i] = (ctx_q.sgn && (numer_q[i][31] ^ denom_q[i][31])) ? -quo_q[i]
                                                                         : quo_q[i];
            r_fix[i] = (ctx_q.sgn && numer_q[i][31]) ? -rem_q[i] : rem_q[i];
            if (denom_q[i] == '0) begin
                q_fix[i] = '1;
                r_fix[i] = numer_q[i];
            end
        end
    end

    // ########################################################
    // control
    // ########################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (in_valid) state <= LOAD;
                LOAD: begin
                    cnt   <= '0;
                    state <= ITER;
                end
                ITER: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31) state <= FIX;
                end
                FIX:  state <= DONE;
                DONE: if (out_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (in_valid) begin
                    numer_q     <= numer;
                    denom_q     <= denom;
                    ctx_q.tag   <= in_tag;
                    ctx_q.tmask <= in_tmask;
                    ctx_q.sgn   <= signed_mode;
                    ctx_q.rem   <= rem_sel;
                end
            end
            LOAD: begin
                quo_q  <= n_abs;   // dividend shifts out of the quotient reg
                dmag_q <= d_abs;
                rem_q  <= '0;
            end
            ITER: begin
                for (int i = 0; i < NUM_THREADS; i++) begin
                    quo_q[i] <= {quo_q[i][30:0], ~diff[i][32]};
                    rem_q[i] <= diff[i][32] ? r_shift[i][31:0] : diff[i][31:0];
                end
            end
            FIX: res_q <= ctx_q.rem ? r_fix : q_fix;
            default: ;
        endcase
    end

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == DONE);
    assign out_tag   = ctx_q.tag;
    assign out_tmask = ctx_q.tmask;
    assign out_data  = res_q;

    a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == DONE && !out_ready) |=>
            (state == DONE && $stable(out_data) && $stable(out_tag)))
        else $error("divider result not held without out_ready");

endmodule

// ==== verilog/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit #(
    parameter int NUM_THREADS  = 4,
    parameter int LATENCY_IMUL = 3
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  muldiv_pkg::muldiv_req_t      in_req,
    input  logic [NUM_THREADS-1:0]       in_tmask,
    input  logic [NUM_THREADS-1:0][31:0] a,
    input  logic [NUM_THREADS-1:0][31:0] b,
    output logic                         out_valid,
    input  logic                         out_ready,
    output muldiv_pkg::muldiv_tag_t      out_tag,
    output logic [NUM_THREADS-1:0]       out_tmask,
    output logic [NUM_THREADS-1:0][31:0] out_data
);
    import muldiv_pkg::*;

    typedef struct packed {
        muldiv_tag_t                  tag;
        logic [NUM_THREADS-1:0]       tmask;
        logic [NUM_THREADS-1:0][31:0] data;
    } rsp_t;

    logic is_div;
    logic stall_out;

    logic                         mul_valid_in, mul_enable, mul_valid_out;
    muldiv_tag_t                  mul_tag;
    logic [NUM_THREADS-1:0]       mul_tmask;
    logic [NUM_THREADS-1:0][31:0] mul_result;

    logic                         div_valid_in, div_ready_in;
    logic                         div_valid_out, div_ready_out;
    muldiv_tag_t                  div_tag;
    logic [NUM_THREADS-1:0]       div_tmask;
    logic [NUM_THREADS-1:0][31:0] div_data;

    rsp_t rsp_d, rsp_q;

    assign is_div    = is_div_op(in_req.op);
    assign stall_out = out_valid && !out_ready;

    // ########################################################
    // multiply path
    // ########################################################

    assign mul_valid_in = in_valid && !is_div;
    assign mul_enable   = !stall_out || !mul_valid_out;  // bubble in last stage lets it move

    mul_pipeline #(
        .NUM_THREADS  (NUM_THREADS),
        .LATENCY_IMUL (LATENCY_IMUL)
    ) mul_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (mul_enable),
        .in_valid  (mul_valid_in),
        .in_req    (in_req),
        .in_tmask  (in_tmask),
        .a         (a),
        .b         (b),
        .out_valid (mul_valid_out),
        .out_tag   (mul_tag),
        .out_tmask (mul_tmask),
        .result    (mul_result)
    );

    // ########################################################
    // divide path
    // ########################################################

    assign div_valid_in  = in_valid && is_div;
    assign div_ready_out = !stall_out && !mul_valid_out;  // multiply wins

    serial_divider #(
        .NUM_THREADS (NUM_THREADS)
    ) div_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (div_valid_in),
        .in_ready    (div_ready_in),
        .signed_mode (div_signed(in_req.op)),
        .in_tag      (in_req.tag),
        .in_tmask    (in_tmask),
        .rem_sel     (is_rem(in_req.op)),
        .numer       (a),
        .denom       (b),
        .out_valid   (div_valid_out),
        .out_ready   (div_ready_out),
        .out_tag     (div_tag),
        .out_tmask   (div_tmask),
        .out_data    (div_data)
    );

    assign in_ready = is_div ? div_ready_in : mul_enable;

    // merge and output register
    assign rsp_d.tag   = mul_valid_out ? mul_tag : div_tag;
    assign rsp_d.tmask = mul_valid_out ? mul_tmask : div_tmask;
    assign rsp_d.data  = mul_valid_out ? mul_result : div_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!stall_out) begin
            out_valid <= mul_valid_out || div_valid_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_out) rsp_q <= rsp_d;
    end

    assign out_tag   = rsp_q.tag;
    assign out_tmask = rsp_q.tmask;
    assign out_data  = rsp_q.data;

    // a frozen multiplier must still present the same result next cycle
    a_mul_kept: assert property (@(posedge clk) disable iff (!rst_n)
        (mul_valid_out && !mul_enable) |=> (mul_valid_out && $stable(mul_tag)))
        else $error("multiply result lost while stalled");

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stall_out |=> (out_valid && $stable(out_data) && $stable(out_tag)))
        else $error("output changed while stalled");

endmodule

// ==== verilog/muldiv_top.sv ====
`timescale 1ns/1ps

module muldiv_top #(
    parameter int NUM_THREADS  = 4,
    parameter int LATENCY_IMUL = 3
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  muldiv_pkg::muldiv_req_t      req,
    input  logic [NUM_THREADS-1:0]       tmask,
    input  logic [NUM_THREADS-1:0][31:0] a,
    input  logic [NUM_THREADS-1:0][31:0] b,
    input  logic                         valid_in,
    output logic                         ready_in,
    output muldiv_pkg::muldiv_tag_t      rsp_tag,
    output logic [NUM_THREADS-1:0]       rsp_tmask,
    output logic [NUM_THREADS-1:0][31:0] data,
    output logic                         valid_out,
    input  logic                         ready_out
);
    import muldiv_pkg::*;

    muldiv_req_t                  buf_req;
    logic [NUM_THREADS-1:0]       buf_tmask;
    logic [NUM_THREADS-1:0][31:0] buf_a, buf_b;
    logic                         buf_valid, buf_ready;

    muldiv_skid_buf #(
        .NUM_THREADS (NUM_THREADS)
    ) skid_i (
        .clk (clk), .rst_n (rst_n),
        .in_req (req), .in_tmask (tmask), .in_a (a), .in_b (b),
        .in_valid (valid_in), .in_ready (ready_in),
        .out_req (buf_req), .out_tmask (buf_tmask), .out_a (buf_a), .out_b (buf_b),
        .out_valid (buf_valid), .out_ready (buf_ready)
    );

    muldiv_unit #(
        .NUM_THREADS  (NUM_THREADS),
        .LATENCY_IMUL (LATENCY_IMUL)
    ) unit_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid (buf_valid), .in_ready (buf_ready),
        .in_req (buf_req), .in_tmask (buf_tmask), .a (buf_a), .b (buf_b),
        .out_valid (valid_out), .out_ready (ready_out),
        .out_tag (rsp_tag), .out_tmask (rsp_tmask), .out_data (data)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;   // released just after the last reset edge
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== tb/muldiv_tb.sv ====
`timescale 1ns/1ps

module muldiv_tb;
    import muldiv_pkg::*;

    localparam int NUM_THREADS  = 4;
    localparam int LATENCY_IMUL = 3;
    localparam int NUM_VEC      = 40;   // last entry is the latency probe
    localparam int PERIOD_NS    = 40;
    localparam logic [UUID_BITS-1:0] UUID_BASE = 44'h0ab_cd00_0000;

    typedef struct packed {
        mul_op_e                      op;
        muldiv_tag_t                  tag;
        logic [NUM_THREADS-1:0]       tmask;
        logic [NUM_THREADS-1:0][31:0] a;
        logic [NUM_THREADS-1:0][31:0] b;
        logic [NUM_THREADS-1:0][31:0] exp_res;
    } vec_t;

    logic                         clk, rst_n;
    muldiv_req_t                  req;
    logic [NUM_THREADS-1:0]       tmask, rsp_tmask;
    logic [NUM_THREADS-1:0][31:0] a, b, data, held_data;
    logic                         valid_in, ready_in, valid_out, ready_out;
    muldiv_tag_t                  rsp_tag, held_tag;

    vec_t        tbl [NUM_VEC];
    int          seen [NUM_VEC];
    int          errors, rsp_count, overtakes, issue_cyc, rsp_cyc;
    int          cyc = 0;
    logic [31:0] rng;
    logic        hold_ready, stall_q;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(10)) clk_i (.clk(clk), .rst_n(rst_n));

    muldiv_top #(
        .NUM_THREADS  (NUM_THREADS),
        .LATENCY_IMUL (LATENCY_IMUL)
    ) dut_i (
        .clk (clk), .rst_n (rst_n),
        .req (req), .tmask (tmask), .a (a), .b (b),
        .valid_in (valid_in), .ready_in (ready_in),
        .rsp_tag (rsp_tag), .rsp_tmask (rsp_tmask), .data (data),
        .valid_out (valid_out), .ready_out (ready_out)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // RISC-V M rules, straight from 64-bit arithmetic
    function automatic logic [31:0] ref_result(mul_op_e op, logic [31:0] x, logic [31:0] y);
        logic [63:0]        xs, xu, ys, yu, p;
        logic signed [31:0] sx, sy, sq, sr;
        logic               ovf;
        xs  = {{32{x[31]}}, x};
        xu  = {32'd0, x};
        ys  = {{32{y[31]}}, y};
        yu  = {32'd0, y};
        sx  = x;
        sy  = y;
        ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
        sq  = 32'sh8000_0000;   // values for the overflow case
        sr  = '0;
        if (y != 32'd0 && !ovf) begin
            sq = sx / sy;
            sr = sx % sy;
        end
        case (op)
            OP_MUL:    p = xs * ys;
            OP_MULH:   p = (xs * ys) >> 32;
            OP_MULHSU: p = (xs * yu) >> 32;
            OP_MULHU:  p = (xu * yu) >> 32;
            OP_DIV:    p = (y == 32'd0) ? 64'hffff_ffff : {32'd0, sq};
            OP_DIVU:   p = (y == 32'd0) ? 64'hffff_ffff : {32'd0, x / y};
            OP_REM:    p = (y == 32'd0) ? {32'd0, x} : {32'd0, sr};
            default:   p = (y == 32'd0) ? {32'd0, x} : {32'd0, x % y};
        endcase
        return p[31:0];
    endfunction

    task automatic check_val(input string name, input logic [127:0] want, input logic [127:0] got);
        assert (got === want) else begin
            $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, want, got);
            errors++;
        end
    endtask

    // ########################################################
    // stimulus table
    // ########################################################

    task automatic build_table();
        logic [31:0] corner [5];
        mul_op_e     op;
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (int i = 0; i < NUM_VEC; i++) begin
            rng = xorshift32(rng);
            if (i < 16) op = mul_op_e'(i % 8);   // every op twice, divides ahead of muls
            else if (i == NUM_VEC - 1) op = OP_MUL;
            else op = mul_op_e'(rng[2:0]);
            tbl[i].op       = op;
            tbl[i].tag.uuid = UUID_BASE + i;
            tbl[i].tag.wid  = rng[4:3];
            tbl[i].tag.pc   = 32'h8000_0000 + 4 * i;
            tbl[i].tag.rd   = rng[9:5];
            tbl[i].tag.wb   = rng[10];
            tbl[i].tmask    = rng[16 +: NUM_THREADS];
            for (int l = 0; l < NUM_THREADS; l++) begin
                rng = xorshift32(rng);
                tbl[i].a[l] = rng;
                rng = xorshift32(rng);
                tbl[i].b[l] = rng;
                if (i < 16 && l < 3) begin
                    tbl[i].a[l] = corner[(i + l) % 5];
                    tbl[i].b[l] = corner[(i / 2 + 3 * l) % 5];
                end
                if (i < 16 && op >= OP_DIV && l < 2) begin   // lane 0 by zero, lane 1 overflow
                    tbl[i].a[l] = (l == 0) ? rng : 32'h8000_0000;
                    tbl[i].b[l] = (l == 0) ? 32'h0 : 32'hffff_ffff;
                end
                if (i >= 16 && tbl[i].b[l][5]) tbl[i].b[l] = tbl[i].b[l] >> tbl[i].b[l][4:0];
                tbl[i].exp_res[l] = ref_result(op, tbl[i].a[l], tbl[i].b[l]);
            end
        end
    endtask

    task automatic send_request(int i);
        req.op   = tbl[i].op;
        req.tag  = tbl[i].tag;
        tmask    = tbl[i].tmask;
        a        = tbl[i].a;
        b        = tbl[i].b;
        valid_in = 1'b1;
    endtask

    task automatic check_response(int i);
        int      err0;
        mul_op_e op;
        err0 = errors;
        op   = tbl[i].op;
        seen[i]++;
        assert (seen[i] == 1) else begin
            $display("entry %0d answered more than once at %0t", i, $time);
            errors++;
        end
        check_val("rsp_tag", tbl[i].tag, rsp_tag);
        check_val("rsp_tmask", tbl[i].tmask, rsp_tmask);
        for (int l = 0; l < NUM_THREADS; l++) begin
            check_val($sformatf("data[%0d]", l), tbl[i].exp_res[l], data[l]);
        end
        if (op < OP_DIV) begin
            for (int j = 0; j < i; j++) begin
                if (tbl[j].op >= OP_DIV && seen[j] == 0) overtakes++;
            end
        end
        if (i == NUM_VEC - 1) rsp_cyc = cyc;
        rsp_count++;
        $display("test %0d %s uuid %0h: %s", i, op.name(), tbl[i].tag.uuid,
                 (errors == err0) ? "ok" : "FAILED");
    endtask

    // ########################################################
    // response side, random ready_out and stall checks
    // ########################################################

    always @(negedge clk) begin : monitor
        logic [UUID_BITS-1:0] off;
        logic                 nxt_ready;
        if (rst_n) begin
            if (stall_q) begin
                assert (valid_out === 1'b1) else begin
                    $display("valid_out dropped at %0t while ready_out was low", $time);
                    errors++;
                end
                check_val("held data", held_data, data);
                check_val("held rsp_tag", held_tag, rsp_tag);
            end
            rng       = xorshift32(rng);
            nxt_ready = hold_ready || (rng[1:0] != 2'b00);
            if (valid_out === 1'b1 && nxt_ready) begin   // transfer on the coming edge
                off = rsp_tag.uuid - UUID_BASE;
                assert (off < NUM_VEC) else begin
                    $display("response with unknown uuid %0h at %0t", rsp_tag.uuid, $time);
                    errors++;
                end
                if (off < NUM_VEC) check_response(int'(off));
            end
            stall_q   = (valid_out === 1'b1) && !nxt_ready;
            held_data = data;
            held_tag  = rsp_tag;
            ready_out = nxt_ready;
        end
    end

    initial begin : watchdog
        #(NUM_VEC * 50 * PERIOD_NS * 2);
        $display("timeout with %0d of %0d responses seen", rsp_count, NUM_VEC);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rng        = 32'h7b7d_02a3;
        req        = '0;
        tmask      = '0;
        a          = '0;
        b          = '0;
        valid_in   = 1'b0;
        ready_out  = 1'b0;
        hold_ready = 1'b0;
        stall_q    = 1'b0;
        errors     = 0;
        rsp_count  = 0;
        overtakes  = 0;
        issue_cyc  = 0;
        rsp_cyc    = 0;
        for (int i = 0; i < NUM_VEC; i++) seen[i] = 0;
        build_table();
        wait (rst_n === 1'b1);
        @(negedge clk);

        // mixed stream under random back-pressure
        for (int i = 0; i < NUM_VEC - 1; i++) begin
            while (ready_in !== 1'b1) begin
                valid_in = 1'b0;
                @(negedge clk);
            end
            send_request(i);
            @(negedge clk);
        end
        valid_in = 1'b0;
        wait (rsp_count == NUM_VEC - 1);

        // single multiply on an idle unit
        hold_ready = 1'b1;
        repeat (4) @(negedge clk);
        while (ready_in !== 1'b1) @(negedge clk);
        send_request(NUM_VEC - 1);
        issue_cyc = cyc;
        @(negedge clk);
        valid_in = 1'b0;
        wait (rsp_count == NUM_VEC);
        repeat (20) @(negedge clk);   // room for a stray extra response

        for (int i = 0; i < NUM_VEC; i++) begin
            assert (seen[i] == 1) else begin
                $display("entry %0d got %0d responses instead of one", i, seen[i]);
                errors++;
            end
        end
        check_val("valid_out latency", LATENCY_IMUL + 2, rsp_cyc - issue_cyc);
        assert (overtakes > 0) else begin
            $display("no multiply completed ahead of an older divide");
            errors++;
        end
        $display("summary: %0d tests, %0d responses, %0d overtakes, %0d errors",
                 NUM_VEC, rsp_count, overtakes, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/muldiv_pkg.sv
verilog/muldiv_skid_buf.sv
verilog/mul_pipeline.sv
verilog/serial_divider.sv
verilog/muldiv_unit.sv
verilog/muldiv_top.sv
tb/tb_clock_gen.sv
tb/muldiv_tb.sv

// ==== Bender.yml ====
package:
  name: muldiv

sources:
  - verilog/muldiv_pkg.sv
  - verilog/muldiv_skid_buf.sv
  - verilog/mul_pipeline.sv
  - verilog/serial_divider.sv
  - verilog/muldiv_unit.sv
  - verilog/muldiv_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/muldiv_tb.sv
